// File: Makefile
# Verilator build and run for the bus switch testbench

TOOL     = verilator
FLAGS    = --binary --timing -Wno-fatal
TOP      = testbench
FILELIST = filelist.f
BUILD    = obj_dir
LOG      = sim.log
FAIL_MSG = Some tests failed

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: compile
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ]; then echo "simulator exited with status $$status"; exit 1; fi
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation reported failure"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)

// File: filelist.f
+incdir+.
ibSwitchPkg.sv
ibInputPort.sv
ibOutputArbiter.sv
ibSwitch.sv
ibTest.sv
testbench.sv

// File: ibInputPort.sv
`timescale 1ns/1ps
`include "ibSwitch_config.svh"

module ibInputPort import ibSwitchPkg::*; #(
  parameter int portId = 0 // source port number, 0 is the parent
) (
  input  logic      CLK,
  input  logic      rstN,
  input  ibWord_t   in,      // taken whenever valid is high
  input  portMask_t pop,     // bit j from output arbiter j
  output ibWord_t   head,    // front word, valid when not empty
  output portMask_t destMask // decoded targets, only at sop
);

  localparam int depth = `IB_FIFO_DEPTH;
  localparam int ptrW  = $clog2(depth);

  // word storage
  ibWord_t mem [depth];

  logic [ptrW-1:0]  wrPtr;
  logic [ptrW-1:0]  rdPtr;
  logic [ptrW:0]    count;      // one extra bit so full != empty
  logic             notEmpty;
  logic             doPush;
  logic             doPop;
  logic             arbPop;     // any arbiter taking a word
  logic             selfPop;    // drop path
  logic             unroutable; // sop with no target
  logic             discarding; // inside a dropped packet
  logic [addrW-1:0] headAddr;
  logic             hit1;
  logic             hit2;

  assign notEmpty = (count != '0);
  assign doPush   = in.valid;

  // front word, valid bit replaced by occupancy
  always_comb begin
    head       = mem[rdPtr];
    head.valid = notEmpty;
  end

  // address field of the header word
  assign headAddr = head.data[`IB_ADDR_LSB +: addrW];

  assign hit1 = ((headAddr & `IB_PORT1_MASK) == `IB_PORT1_BASE);
  assign hit2 = ((headAddr & `IB_PORT2_MASK) == `IB_PORT2_BASE);

  // routing decode
  // a window of our own port never matches, so children fall back to the parent
  always_comb begin
    destMask = '0;
    if (head.valid && head.sop) begin
      if (hit1 && (portId != 1)) begin
        destMask[1] = 1'b1;
      end else if (hit2 && (portId != 2)) begin
        destMask[2] = 1'b1;
      end else if (portId != 0) begin
        destMask[0] = 1'b1; // upstream to parent
      end
      // parent with no hit stays empty -> dropped
    end
  end

  assign unroutable = head.valid && head.sop && (destMask == '0);

  // drop sop here, then keep draining until eop leaves
  assign selfPop = unroutable || (discarding && notEmpty);

  assign arbPop = |pop; // only one arbiter may be locked on us
  assign doPop  = selfPop || arbPop;

  always_ff @(posedge CLK) begin
    if (doPush) begin
      mem[wrPtr] <= in;
    end
  end

  always_ff @(posedge CLK) begin
    if (!rstN) begin
      wrPtr      <= '0;
      rdPtr      <= '0;
      count      <= '0;
      discarding <= 1'b0;
    end else begin
      if (doPush) begin
        wrPtr <= wrPtr + 1'b1; // wraps, depth is 2^n
      end
      if (doPop) begin
        rdPtr <= rdPtr + 1'b1;
      end
      case ({doPush, doPop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count; // both or neither
      endcase
      // single-word drop never enters the state
      if (selfPop) begin
        discarding <= !head.eop;
      end
    end
  end

endmodule

// File: ibOutputArbiter.sv
`timescale 1ns/1ps

module ibOutputArbiter import ibSwitchPkg::*; #(
  parameter int portId = 0 // output port served
) (
  input  logic      CLK,
  input  logic      rstN,
  input  ibWord_t   head0,
  input  ibWord_t   head1,
  input  ibWord_t   head2,
  input  portMask_t mask0,
  input  portMask_t mask1,
  input  portMask_t mask2,
  output portMask_t pop,  // bit i pops input i
  output ibWord_t   out   // registered output word
);

  ibWord_t   heads [numPorts];
  portMask_t masks [numPorts];

  logic [numPorts-1:0] request;    // sop heads aimed at us
  logic                locked;     // mid-packet
  portIdx_t            lockSrc;    // input being streamed
  portIdx_t            rrPtr;      // last granted input
  logic                grantValid;
  portIdx_t            grantSrc;
  logic                popValid;
  portIdx_t            popSrc;
  ibWord_t             popWord;    // word taken this cycle

  assign heads[0] = head0;
  assign heads[1] = head1;
  assign heads[2] = head2;
  assign masks[0] = mask0;
  assign masks[1] = mask1;
  assign masks[2] = mask2;

  // own input never targets itself
  always_comb begin
    for (int i = 0; i < numPorts; i++) begin
      request[i] = (i != portId) && heads[i].valid && heads[i].sop
                   && masks[i][portId];
    end
  end

  // first requester after rrPtr, wrapping mod 3
  always_comb begin
    portIdx_t cand;
    grantValid = 1'b0;
    grantSrc   = rrPtr;
    for (int k = 1; k <= numPorts; k++) begin
      cand = portIdx_t'((int'(rrPtr) + k) % numPorts);
      if (!grantValid && request[cand]) begin
        grantValid = 1'b1;
        grantSrc   = cand;
      end
    end
  end

  // locked input already holds its whole packet
  assign popSrc   = locked ? lockSrc : grantSrc;
  assign popValid = locked ? heads[lockSrc].valid : grantValid;

  always_comb begin
    pop     = '0;
    popWord = '0;
    if (popValid) begin
      pop[popSrc] = 1'b1;
      popWord     = heads[popSrc];
    end
  end

  always_ff @(posedge CLK) begin
    if (!rstN) begin
      locked  <= 1'b0;
      lockSrc <= '0;
      rrPtr   <= portIdx_t'(portId); // first look at next port up
    end else begin
      if (!locked && grantValid) begin
        rrPtr   <= grantSrc; // rotate per packet
        lockSrc <= grantSrc;
        locked  <= !popWord.eop; // one-word packet needs no lock
      end else if (locked && popValid && popWord.eop) begin
        locked <= 1'b0;
      end
    end
  end

  // output stage, one cycle behind the pop
  always_ff @(posedge CLK) begin
    out.sop  <= popWord.sop;
    out.eop  <= popWord.eop;
    out.data <= popWord.data;
    if (!rstN) begin
      out.valid <= 1'b0;
    end else begin
      out.valid <= popValid;
    end
  end

endmodule

// File: ibSwitch.sv
`timescale 1ns/1ps

module ibSwitch import ibSwitchPkg::*; (
  input  logic    CLK,
  input  logic    rstN,
  input  ibWord_t portIn0,  // parent
  input  ibWord_t portIn1,  // child 1
  input  ibWord_t portIn2,  // child 2
  output ibWord_t portOut0,
  output ibWord_t portOut1,
  output ibWord_t portOut2
);

  ibWord_t   inWord   [numPorts];
  ibWord_t   outWord  [numPorts];
  ibWord_t   head     [numPorts]; // buffer fronts
  portMask_t destMask [numPorts];
  portMask_t arbPop   [numPorts]; // indexed by arbiter, bit per input
  portMask_t inPop    [numPorts]; // indexed by input, bit per arbiter

  assign inWord[0] = portIn0;
  assign inWord[1] = portIn1;
  assign inWord[2] = portIn2;

  assign portOut0 = outWord[0];
  assign portOut1 = outWord[1];
  assign portOut2 = outWord[2];

  for (genvar gi = 0; gi < numPorts; gi++) begin : gPort

    // transpose, input gi collects its bit from each arbiter
    assign inPop[gi] = {arbPop[2][gi], arbPop[1][gi], arbPop[0][gi]};

    ibInputPort #(
      .portId (gi)
    ) uInPort (
      .CLK      (CLK),
      .rstN     (rstN),
      .in       (inWord[gi]),
      .pop      (inPop[gi]),
      .head     (head[gi]),
      .destMask (destMask[gi])
    );

    // each arbiter sees all three inputs and skips its own
    ibOutputArbiter #(
      .portId (gi)
    ) uArb (
      .CLK   (CLK),
      .rstN  (rstN),
      .head0 (head[0]),
      .head1 (head[1]),
      .head2 (head[2]),
      .mask0 (destMask[0]),
      .mask1 (destMask[1]),
      .mask2 (destMask[2]),
      .pop   (arbPop[gi]),
      .out   (outWord[gi])
    );

  end

endmodule

// File: ibSwitchPkg.sv
`include "ibSwitch_config.svh"

package ibSwitchPkg;

  // one parent port plus two children
  localparam int numPorts = 3;

  // destination address field width in the sop word
  localparam int addrW = 32;

  // one bus word, same layout on every port
  typedef struct packed {
    logic                  valid; // word present this cycle
    logic                  sop;   // first word, carries address
    logic                  eop;   // last word of packet
    logic [`IB_DATA_W-1:0] data;
  } ibWord_t;

  // one bit per port, bit 0 is the parent
  typedef logic [numPorts-1:0] portMask_t;

  // port number 0..2
  typedef logic [1:0] portIdx_t;

endpackage

// File: ibSwitch_config.svh
`ifndef IB_SWITCH_CONFIG_SVH
`define IB_SWITCH_CONFIG_SVH

// bus word payload width
`define IB_DATA_W 64

// lowest bit of the 32-bit destination address in a sop word
`define IB_ADDR_LSB 0

// child port 1 window
`define IB_PORT1_BASE 32'h1000_0000
`define IB_PORT1_MASK 32'hF000_0000

// child port 2 window, same size as port 1
`define IB_PORT2_BASE 32'h2000_0000
`define IB_PORT2_MASK 32'hF000_0000

// input buffer depth in words, power of two only
`define IB_FIFO_DEPTH 32

// longest packet in words
// also sets the idle gap a sender keeps after each packet
`define IB_MAX_PKT 8

`endif

// File: ibTest.sv
`timescale 1ns/1ps
`include "ibSwitch_config.svh"

module ibTest import ibSwitchPkg::*; #(
  parameter int numRandom = 200 // random packets in behavior 5
) (
  input  logic    CLK,
  input  logic    rstN,
  output ibWord_t portIn0,
  output ibWord_t portIn1,
  output ibWord_t portIn2,
  input  ibWord_t portOut0,
  input  ibWord_t portOut1,
  input  ibWord_t portOut2,
  output logic    done,
  output int      valueErrs,
  output int      streamErrs,
  output int      testErrs
);

  localparam int gapCycles = 2 * `IB_MAX_PKT + 4; // idle after each packet

  ibWord_t     drv [3];        // driven words, one per source
  ibWord_t     outs [3];
  logic [63:0] rngState = 64'd95;
  logic [63:0] sbData [3][3][$]; // expected words per (src, dst)
  int          sbLen [3][3][$];  // expected packet lengths
  logic [63:0] curPkt [3][$];    // packet being rebuilt per output
  logic        inPkt [3];
  logic [31:0] rAddr [3][$];     // random packets, per source
  int          rLen [3][$];
  logic [63:0] rSeed [3][$];
  int          dataErrCnt = 0;
  int          streamErrCnt = 0;

  assign portIn0 = drv[0];
  assign portIn1 = drv[1];
  assign portIn2 = drv[2];
  assign outs[0] = portOut0;
  assign outs[1] = portOut1;
  assign outs[2] = portOut2;
  assign valueErrs  = dataErrCnt;
  assign streamErrs = streamErrCnt;

  function automatic logic [63:0] xorshift(input logic [63:0] v);
    logic [63:0] x;
    x = v;
    x = x ^ (x << 13);
    x = x ^ (x >> 7);
    x = x ^ (x << 17);
    return x;
  endfunction

  function automatic logic [63:0] nextRand();
    rngState = xorshift(rngState);
    return rngState;
  endfunction

  // expected destination, -1 when the packet is dropped
  function automatic int routeOf(input int src, input logic [31:0] addr);
    logic in1;
    logic in2;
    in1 = ((addr & `IB_PORT1_MASK) == `IB_PORT1_BASE);
    in2 = ((addr & `IB_PORT2_MASK) == `IB_PORT2_BASE);
    if (in1 && src != 1) return 1;
    if (in2 && src != 2) return 2;
    if (src != 0) return 0; // child traffic goes up
    return -1;
  endfunction

  // words derive from seed, so threads share no generator state
  task automatic sendPkt(input int src, input logic [31:0] addr, input int len,
                         input logic [63:0] seed);
    logic [63:0] x;
    logic [63:0] d;
    ibWord_t     w;
    int          dst;
    x   = seed;
    dst = routeOf(src, addr);
    if (dst >= 0) sbLen[src][dst].push_back(len);
    for (int i = 0; i < len; i++) begin
      x = xorshift(x);
      d = (i == 0) ? {x[63:32], addr} : x; // address in low half of sop
      if (dst >= 0) sbData[src][dst].push_back(d);
      @(posedge CLK);
      #1;
      w.valid   = 1'b1;
      w.sop     = (i == 0);
      w.eop     = (i == len - 1);
      w.data    = d;
      drv[src]  = w;
    end
    @(posedge CLK);
    #1;
    drv[src] = '0;
    repeat (gapCycles) @(posedge CLK); // load rule
  endtask

  task automatic sendStream(input int src);
    while (rAddr[src].size() > 0) begin
      sendPkt(src, rAddr[src].pop_front(), rLen[src].pop_front(), rSeed[src].pop_front());
    end
  endtask

  // match finished packet on output d to a stream by first word
  task automatic checkPacket(input int d);
    int          src;
    int          len;
    logic [63:0] exp;
    src = -1;
    for (int s = 0; s < 3; s++) begin
      if (src < 0 && s != d && sbLen[s][d].size() > 0) begin
        if (sbData[s][d][0] == curPkt[d][0]) src = s;
      end
    end
    assert (src >= 0) else begin
      streamErrCnt++;
      $display("unexpected packet on portOut%0d, first word %h matches no sent packet",
               d, curPkt[d][0]);
    end
    if (src >= 0) begin
      len = sbLen[src][d].pop_front();
      assert (curPkt[d].size() == len) else begin
        streamErrCnt++;
        $display("packet from port %0d on portOut%0d has %0d words instead of %0d",
                 src, d, curPkt[d].size(), len);
      end
      for (int i = 0; i < len; i++) begin
        exp = sbData[src][d].pop_front();
        if (i < curPkt[d].size()) begin
          assert (curPkt[d][i] == exp) else begin
            dataErrCnt++;
            $display("FAILED portOut%0d.data word %0d: expected %h, got %h",
                     d, i, exp, curPkt[d][i]);
          end
        end
      end
    end
    curPkt[d].delete();
  endtask

  // compare process, outputs settled by the falling edge
  always @(negedge CLK) begin : compare
    ibWord_t w;
    if (rstN === 1'b1) begin
      for (int d = 0; d < 3; d++) begin
        w = outs[d];
        if (w.valid === 1'b1) begin
          if (w.sop) begin
            assert (!inPkt[d]) else begin
              streamErrCnt++;
              $display("portOut%0d: sop inside an open packet, packets interleaved", d);
            end
            curPkt[d].delete();
            inPkt[d] = 1'b1;
          end
          assert (inPkt[d]) else begin
            streamErrCnt++;
            $display("portOut%0d: word arrived without a preceding sop", d);
          end
          if (inPkt[d]) curPkt[d].push_back(w.data);
          if (inPkt[d] && w.eop) begin
            checkPacket(d);
            inPkt[d] = 1'b0;
          end
        end
      end
    end
  end

  initial begin : mainSeq
    logic [63:0] seedA;
    logic [63:0] seedB;
    logic [63:0] r;
    logic [31:0] addr;
    int          s;
    for (int i = 0; i < 3; i++) begin
      drv[i]   = '0;
      inPkt[i] = 1'b0;
    end
    done     = 1'b0;
    testErrs = 0;
    wait (rstN === 1'b1);
    // quiet outputs after reset
    repeat (10) begin
      @(negedge CLK);
      assert (!(portOut0.valid || portOut1.valid || portOut2.valid)) else begin
        testErrs++;
        $display("an output showed valid after reset with idle inputs");
      end
    end
    // child 1 traffic
    sendPkt(1, 32'h2000_0040, 4, nextRand()); // to port 2
    sendPkt(1, 32'h1000_0100, 3, nextRand()); // own window, goes up
    sendPkt(1, 32'h5000_0000, 1, nextRand()); // no window, goes up
    // parent traffic, one dropped in the middle
    sendPkt(0, 32'h1234_5678, 5, nextRand());
    sendPkt(0, 32'h2abc_0000, 2, nextRand());
    sendPkt(0, 32'h8000_0000, 6, nextRand()); // dropped
    sendPkt(0, 32'h1000_0004, 1, nextRand());
    sendPkt(0, 32'h2000_0008, `IB_MAX_PKT, nextRand());
    // contention on port 2, same cycle
    seedA = nextRand();
    seedB = nextRand();
    fork
      sendPkt(0, 32'h2000_1000, `IB_MAX_PKT, seedA);
      sendPkt(1, 32'h2fff_0000, `IB_MAX_PKT, seedB);
    join
    // random traffic, sources run in parallel
    for (int n = 0; n < numRandom; n++) begin
      r = nextRand();
      s = int'(r[7:0] % 3);
      case (r[17:16])
        2'd0:    addr = {4'h1, r[59:32]};
        2'd1:    addr = {4'h2, r[59:32]};
        2'd2:    addr = {4'h0, r[59:32]};
        default: addr = {1'b1, r[62:32]}; // top nibble 8..F
      endcase
      rAddr[s].push_back(addr);
      rLen[s].push_back(1 + int'(r[15:8] % `IB_MAX_PKT));
      rSeed[s].push_back(nextRand());
    end
    fork
      sendStream(0);
      sendStream(1);
      sendStream(2);
    join
    repeat (4 * `IB_MAX_PKT + 20) @(posedge CLK); // drain
    for (int i = 0; i < 3; i++) begin
      for (int j = 0; j < 3; j++) begin
        assert (sbLen[i][j].size() == 0) else begin
          testErrs++;
          $display("%0d packet(s) from port %0d to port %0d never arrived",
                   sbLen[i][j].size(), i, j);
        end
      end
      assert (!inPkt[i]) else begin
        testErrs++;
        $display("portOut%0d stopped inside a packet, eop never came", i);
      end
    end
    done = 1'b1;
  end

endmodule

// File: testbench.sv
`timescale 1ns/1ps
`include "ibSwitch_config.svh"

module testbench import ibSwitchPkg::*; ();

  localparam int numRandom   = 200;
  localparam int numDirected = 10; // behaviors 2 to 4
  localparam int numPkts     = numRandom + numDirected;
  // per packet budget plus margin for reset and drain
  localparam int timeoutNs   = numPkts * (2 * `IB_MAX_PKT + 6) * 8 + 2000;

  logic    CLK;
  logic    rstN;
  ibWord_t portIn0;
  ibWord_t portIn1;
  ibWord_t portIn2;
  ibWord_t portOut0;
  ibWord_t portOut1;
  ibWord_t portOut2;
  logic    done;       // test sequence finished
  int      valueErrs;  // data mismatches
  int      streamErrs; // framing and unexpected packets
  int      testErrs;   // idle and end-of-run checks

  initial CLK = 1'b0;
  always #4 CLK = ~CLK; // 8 ns period

  // sync reset, low for 8 cycles
  initial begin
    rstN = 1'b0;
    repeat (8) @(posedge CLK);
    #1;
    rstN = 1'b1;
  end

  ibSwitch dut_i (
    .CLK      (CLK),
    .rstN     (rstN),
    .portIn0  (portIn0),
    .portIn1  (portIn1),
    .portIn2  (portIn2),
    .portOut0 (portOut0),
    .portOut1 (portOut1),
    .portOut2 (portOut2)
  );

  ibTest #(
    .numRandom (numRandom)
  ) test_i (
    .CLK        (CLK),
    .rstN       (rstN),
    .portIn0    (portIn0),
    .portIn1    (portIn1),
    .portIn2    (portIn2),
    .portOut0   (portOut0),
    .portOut1   (portOut1),
    .portOut2   (portOut2),
    .done       (done),
    .valueErrs  (valueErrs),
    .streamErrs (streamErrs),
    .testErrs   (testErrs)
  );

  initial begin : finalReport
    wait (done === 1'b1);
    $display("errors: %0d data, %0d stream, %0d test", valueErrs, streamErrs, testErrs);
    if ((valueErrs + streamErrs + testErrs) == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  initial begin : watchdog
    #(timeoutNs);
    $display("timeout: test still running after %0d ns, stimulus or drain never finished",
             timeoutNs);
    $display("Some tests failed");
    $finish;
  end

endmodule
